/* vlog.f */
src/npc_pkg.sv
src/decode_if.sv
src/npc_decoder.sv
src/pc_unit.sv
src/register_file.sv
src/npc_alu.sv
src/npc_top.sv
test/npc_checker.sv
test/npc_assertions.sv
test/npc_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module npc_tb -f vlog.f -o npc_sim \
    && ./obj_dir/npc_sim | tee /dev/stderr | grep -q -F "*** PASSED ***" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* test/npc_tb.sv */
`timescale 1ns/1ps

module npc_tb;
    import npc_pkg::*;

    localparam word_t RESET_PC     = 32'h8000_0000;
    localparam int    MEM_WORDS    = 256;
    localparam int    DATA_BASE    = 128;
    localparam int    HALT_TIMEOUT = 2000;

    logic     clk;
    logic     reset;
    word_t    inst;
    word_t    mem_rdata;
    word_t    pc;
    word_t    mem_addr;
    logic     mem_en;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     halted;

    // program in the low half, data in the high half
    word_t mem [0:MEM_WORDS-1];
    word_t inst_off;
    word_t data_off;
    int    n;
    int    passed;
    int    failed;

    npc_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_en    (mem_en),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    npc_checker #(
        .RESET_PC (RESET_PC)
    ) chk (
        .clk      (clk),
        .reset    (reset),
        .pc       (pc),
        .mem_addr (mem_addr),
        .mem_en   (mem_en),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .halted   (halted)
    );

    always #4 clk = ~clk;

    // same-cycle memory, zero outside the array
    assign inst_off  = pc - RESET_PC;
    assign data_off  = mem_addr - RESET_PC;
    assign inst      = (inst_off < 32'd1024) ? mem[inst_off[9:2]] : '0;
    assign mem_rdata = (data_off < 32'd1024) ? mem[data_off[9:2]] : '0;

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t r_type(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input reg_idx_t rd);
        return {7'd0, rs2, rs1, 3'd0, rd, OPC_OP};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic put_word(input int idx, input word_t w);
        mem[8'(idx)] = w;
        chk.load_word(8'(idx), w);
    endtask

    task automatic emit(input word_t w);
        put_word(n, w);
        n++;
    endtask

    // unused program words halt, data words random
    task automatic fill_image();
        n = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < DATA_BASE) begin
                put_word(i, EBREAK_INSN);
            end else begin
                put_word(i, $urandom);
            end
        end
    endtask

    // x1..x15 set first, then random addi and add over x0..x15
    task automatic build_arith(input int count);
        for (int r = 1; r < 16; r++) begin
            emit(i_type(12'($urandom), 5'd0, 3'd0, 5'(r), OPC_OP_IMM));
        end
        repeat (count) begin
            if ($urandom % 2 == 0) begin
                emit(i_type(12'($urandom), 5'($urandom % 16), 3'd0, 5'($urandom % 16),
                            OPC_OP_IMM));
            end else begin
                emit(r_type(5'($urandom % 16), 5'($urandom % 16), 5'($urandom % 16)));
            end
        end
    endtask

    task automatic run_program(input string name);
        int   start_errors;
        int   cycles;
        logic timed_out;
        start_errors = chk.errors;
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = !halted;
        // a few cycles with the core frozen
        repeat (4) @(negedge clk);
        if (timed_out) begin
            $display("test %s: halted did not rise within %0d cycles", name, HALT_TIMEOUT);
            failed++;
        end else if (chk.errors != start_errors) begin
            $display("test %s: %0d mismatches", name, chk.errors - start_errors);
            failed++;
        end else begin
            $display("test %s: ok", name);
            passed++;
        end
    endtask

    initial begin
        void'($urandom(74));
        clk    = 1'b0;
        reset  = 1'b1;
        n      = 0;
        passed = 0;
        failed = 0;

        fill_image();
        build_arith(24);
        emit(EBREAK_INSN);
        run_program("arithmetic chain");

        fill_image();
        repeat (8) begin
            emit(u_type(20'($urandom), 5'(1 + $urandom % 31), OPC_LUI));
            emit(u_type(20'($urandom), 5'(1 + $urandom % 31), OPC_AUIPC));
        end
        emit(EBREAK_INSN);
        run_program("upper immediates");

        fill_image();
        emit(i_type(12'($urandom), 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        // forward to word 4
        emit(j_type(21'd12, 5'd2));
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
        emit(j_type(21'd12, 5'd4));
        emit(i_type(12'd7, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
        // back to word 3, which jumps on to word 6
        emit(j_type(21'h1F_FFF8, 5'd5));
        emit(u_type(20'd0, 5'd6, OPC_AUIPC));
        // odd offset 21, lands on word 11
        emit(i_type(12'd21, 5'd6, 3'd0, 5'd7, OPC_JALR));
        n = 11;
        emit(r_type(5'd2, 5'd7, 5'd9));
        emit(EBREAK_INSN);
        run_program("jumps");

        fill_image();
        // base register points at the data half
        emit(u_type(20'h8_0000, 5'd5, OPC_LUI));
        emit(i_type(12'h200, 5'd5, 3'd0, 5'd5, OPC_OP_IMM));
        repeat (8) begin
            emit(i_type(12'(($urandom % 128) * 4), 5'd5, 3'd2, 5'(6 + $urandom % 10),
                        OPC_LOAD));
        end
        emit(EBREAK_INSN);
        run_program("loads");

        fill_image();
        build_arith(16);
        emit(EBREAK_INSN);
        run_program("halt");
        run_program("halt and second reset");

        fill_image();
        emit(i_type(12'h040, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        emit(i_type(12'd3, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
        // sw x2, 4(x1)
        emit(32'h0020_A223);
        // beq x1, x1, +8
        emit(32'h0010_8463);
        emit(i_type(12'd1, 5'd2, 3'd0, 5'd3, OPC_OP_IMM));
        emit(EBREAK_INSN);
        run_program("unsupported encodings");

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && chk.errors == 0 && dut.u_assertions.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* test/npc_assertions.sv */
`timescale 1ns/1ps

module npc_assertions #(
    parameter npc_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input logic              clk,
    input logic              reset,
    input npc_pkg::word_t    pc,
    input logic              wb_en,
    input npc_pkg::reg_idx_t wb_rd,
    input logic              halted
);
    // number of failed assertions over the whole run
    int failures = 0;

    // first cycle out of reset fetches from the reset vector
    a_reset_pc: assert property (@(posedge clk) ($past(reset) && !reset) |-> (pc == RESET_PC))
        else begin
            failures++;
            $error("pc not at the reset vector in the first cycle after reset");
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset) wb_en |-> (wb_rd != 5'd0))
        else begin
            failures++;
            $error("register write enabled with x0 as destination");
        end

    // frozen until the next reset
    a_halt_pc: assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
        else begin
            failures++;
            $error("pc moved while halted");
        end

    a_halt_wb: assert property (@(posedge clk) disable iff (reset) halted |-> !wb_en)
        else begin
            failures++;
            $error("register write enabled while halted");
        end

endmodule

bind npc_top npc_assertions #(
    .RESET_PC (RESET_PC)
) u_assertions (
    .clk    (clk),
    .reset  (reset),
    .pc     (pc),
    .wb_en  (wb_en),
    .wb_rd  (wb_rd),
    .halted (halted)
);

/* test/npc_checker.sv */
`timescale 1ns/1ps

module npc_checker #(
    parameter npc_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input logic              clk,
    input logic              reset,
    input npc_pkg::word_t    pc,
    input npc_pkg::word_t    mem_addr,
    input logic              mem_en,
    input logic              wb_en,
    input npc_pkg::reg_idx_t wb_rd,
    input npc_pkg::word_t    wb_data,
    input logic              halted
);
    import npc_pkg::*;

    int       errors = 0;
    word_t    mem [0:255];
    // x0 is never written, so it stays zero
    word_t    regs [0:31] = '{default: '0};
    word_t    shadow_pc;
    logic     shadow_halted;
    logic     exp_wen;
    reg_idx_t exp_rd;
    word_t    exp_data;
    word_t    exp_next;
    logic     exp_halt;
    logic     exp_ld;
    word_t    exp_addr;

    task automatic load_word(input logic [7:0] idx, input word_t w);
        mem[idx] = w;
    endtask

    function automatic word_t read_word(input word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off < 32'd1024) begin
            return mem[off[9:2]];
        end
        return '0;
    endfunction

    // one instruction of the subset from the shadow state
    function automatic void execute(input word_t i, input word_t at, output logic wen,
                                    output reg_idx_t rd, output word_t data,
                                    output word_t next, output logic halt,
                                    output logic ld, output word_t addr);
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      r1;
        word_t      imm_i;
        word_t      imm_u;
        word_t      imm_j;
        opc   = i[6:0];
        f3    = i[14:12];
        rd    = i[11:7];
        r1    = regs[i[19:15]];
        imm_i = {{20{i[31]}}, i[31:20]};
        imm_u = {i[31:12], 12'd0};
        imm_j = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        case (opc)
            OPC_LUI:    data = imm_u;
            OPC_AUIPC:  data = at + imm_u;
            OPC_OP_IMM: data = r1 + imm_i;
            OPC_OP:     data = r1 + regs[i[24:20]];
            OPC_LOAD:   data = read_word(r1 + imm_i);
            default:    data = at + 32'd4;
        endcase
        wen = (opc == OPC_LUI) || (opc == OPC_AUIPC) || (opc == OPC_JAL)
            || (f3 == 3'd0 && (opc == OPC_JALR || opc == OPC_OP_IMM))
            || (f3 == 3'd0 && opc == OPC_OP && i[31:25] == 7'd0)
            || (f3 == 3'd2 && opc == OPC_LOAD);
        if (rd == 5'd0) begin
            wen = 1'b0;
        end
        // memory port is used by lw only
        ld   = (opc == OPC_LOAD) && (f3 == 3'd2);
        addr = ld ? r1 + imm_i : '0;
        next = at + 32'd4;
        if (opc == OPC_JAL) begin
            next = at + imm_j;
        end else if (opc == OPC_JALR && f3 == 3'd0) begin
            next = (r1 + imm_i) & ~32'd1;
        end
        halt = (i == EBREAK_INSN);
        if (halt) begin
            next = at;
        end
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            shadow_pc     = RESET_PC;
            shadow_halted = 1'b0;
        end else begin
            check_value("halted", 32'(shadow_halted), 32'(halted));
            check_value("pc", shadow_pc, pc);
            if (shadow_halted) begin
                check_value("wb_en", 32'd0, 32'(wb_en));
            end else begin
                execute(read_word(shadow_pc), shadow_pc, exp_wen, exp_rd, exp_data,
                        exp_next, exp_halt, exp_ld, exp_addr);
                check_value("wb_en", 32'(exp_wen), 32'(wb_en));
                check_value("mem_en", 32'(exp_ld), 32'(mem_en));
                check_value("mem_addr", exp_addr, mem_addr);
                if (exp_wen) begin
                    check_value("wb_rd", 32'(exp_rd), 32'(wb_rd));
                    check_value("wb_data", exp_data, wb_data);
                    regs[exp_rd] = exp_data;
                end
                shadow_pc     = exp_next;
                shadow_halted = exp_halt;
            end
        end
    end

endmodule

/* src/npc_top.sv */
`timescale 1ns/1ps

module npc_top #(
    parameter npc_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  npc_pkg::word_t    inst,
    input  npc_pkg::word_t    mem_rdata,
    output npc_pkg::word_t    pc,
    output npc_pkg::word_t    mem_addr,
    output logic              mem_en,
    output logic              wb_en,
    output npc_pkg::reg_idx_t wb_rd,
    output npc_pkg::word_t    wb_data,
    output logic              halted
);
    import npc_pkg::*;

    word_t target;
    word_t rdata1;
    word_t rdata2;
    word_t result;

    decode_if dec ();

    npc_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk    (clk),
        .reset  (reset),
        .dec    (dec),
        .target (target),
        .pc     (pc),
        .halted (halted)
    );

    register_file u_register_file (
        .clk    (clk),
        .dec    (dec),
        .wdata  (result),
        .halted (halted),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb_en  (wb_en)
    );

    npc_alu u_alu (
        .dec       (dec),
        .pc        (pc),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .mem_rdata (mem_rdata),
        .result    (result),
        .mem_addr  (mem_addr),
        .target    (target)
    );

    // writeback and load request seen from outside
    assign mem_en  = dec.mem_en;
    assign wb_rd   = dec.rd;
    assign wb_data = result;

endmodule

/* src/npc_alu.sv */
`timescale 1ns/1ps

module npc_alu (
    decode_if.alu          dec,
    input  npc_pkg::word_t pc,
    input  npc_pkg::word_t rdata1,
    input  npc_pkg::word_t rdata2,
    input  npc_pkg::word_t mem_rdata,
    output npc_pkg::word_t result,
    output npc_pkg::word_t mem_addr,
    output npc_pkg::word_t target
);
    import npc_pkg::*;

    word_t pc_plus_4;
    word_t pc_plus_imm;
    word_t base_plus_imm;

    assign pc_plus_4     = pc + 32'd4;
    assign pc_plus_imm   = pc + dec.imm;
    assign base_plus_imm = rdata1 + dec.imm;

    // writeback value
    always_comb begin
        case (dec.op)
            ALU_AUIPC: result = pc_plus_imm;
            ALU_LUI:   result = dec.imm;
            ALU_JAL:   result = pc_plus_4;
            ALU_JALR:  result = pc_plus_4;
            ALU_ADDI:  result = base_plus_imm;
            ALU_ADD:   result = rdata1 + rdata2;
            ALU_LW:    result = mem_rdata;
            default:   result = '0;
        endcase
    end

    // load address only when a load is decoded
    assign mem_addr = (dec.op == ALU_LW) ? base_plus_imm : '0;

    // jalr clears bit 0 of the computed target
    always_comb begin
        if (dec.op == ALU_JALR) begin
            target = {base_plus_imm[31:1], 1'b0};
        end else begin
            target = pc_plus_imm;
        end
    end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic           clk,
    decode_if.regs         dec,
    input  npc_pkg::word_t wdata,
    input  logic           halted,
    output npc_pkg::word_t rdata1,
    output npc_pkg::word_t rdata2,
    output logic           wb_en
);
    import npc_pkg::*;

    // x1 to x31, x0 has no storage
    word_t regs [1:31];

    // reads of x0 return zero
    always_comb begin
        if (dec.rs1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[dec.rs1];
        end
        if (dec.rs2 == 5'd0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[dec.rs2];
        end
    end

    assign wb_en = dec.reg_wen && !halted && (dec.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[dec.rd] <= wdata;
        end
    end

endmodule

/* src/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
    parameter npc_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic           clk,
    input  logic           reset,
    decode_if.pcu          dec,
    input  npc_pkg::word_t target,
    output npc_pkg::word_t pc,
    output logic           halted
);
    import npc_pkg::*;

    word_t next_pc;

    always_comb begin
        if (halted || dec.ebreak) begin
            // frozen at the ebreak address
            next_pc = pc;
        end else if (dec.op == ALU_JAL || dec.op == ALU_JALR) begin
            next_pc = target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else begin
            pc <= next_pc;
            if (dec.ebreak) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* src/npc_decoder.sv */
`timescale 1ns/1ps

module npc_decoder (
    input npc_pkg::word_t inst,
    decode_if.decoder     dec
);
    import npc_pkg::*;

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic [127:0] hot_opcode;
    logic [7:0]   hot_funct3;

    // instruction formats
    logic is_r;
    logic is_i;
    logic is_u;
    logic is_j;

    word_t imm_i;
    word_t imm_u;
    word_t imm_j;

    // individual instructions
    logic is_auipc;
    logic is_lui;
    logic is_jal;
    logic is_jalr;
    logic is_addi;
    logic is_add;
    logic is_lw;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // one-hot match of opcode and funct3
    assign hot_opcode = 128'd1 << opcode;
    assign hot_funct3 = 8'd1 << funct3;

    assign is_r = hot_opcode[OPC_OP];
    assign is_i = hot_opcode[OPC_OP_IMM] | hot_opcode[OPC_LOAD] | hot_opcode[OPC_JALR];
    assign is_u = hot_opcode[OPC_LUI] | hot_opcode[OPC_AUIPC];
    assign is_j = hot_opcode[OPC_JAL];

    // all immediates sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign dec.imm = ({32{is_i}} & imm_i)
                   | ({32{is_u}} & imm_u)
                   | ({32{is_j}} & imm_j);

    assign is_auipc = is_u & hot_opcode[OPC_AUIPC];
    assign is_lui   = is_u & hot_opcode[OPC_LUI];
    assign is_jal   = is_j;
    assign is_jalr  = is_i & hot_opcode[OPC_JALR] & hot_funct3[F3_ZERO];
    assign is_addi  = is_i & hot_opcode[OPC_OP_IMM] & hot_funct3[F3_ZERO];
    // sub shares funct3, so funct7 must be zero too
    assign is_add   = is_r & hot_funct3[F3_ZERO] & (funct7 == 7'd0);
    assign is_lw    = is_i & hot_opcode[OPC_LOAD] & hot_funct3[F3_WORD];

    always_comb begin
        if (is_auipc) begin
            dec.op = ALU_AUIPC;
        end else if (is_lui) begin
            dec.op = ALU_LUI;
        end else if (is_jal) begin
            dec.op = ALU_JAL;
        end else if (is_jalr) begin
            dec.op = ALU_JALR;
        end else if (is_addi) begin
            dec.op = ALU_ADDI;
        end else if (is_add) begin
            dec.op = ALU_ADD;
        end else if (is_lw) begin
            dec.op = ALU_LW;
        end else begin
            dec.op = ALU_NONE;
        end
    end

    assign dec.rs1     = inst[19:15];
    assign dec.rs2     = inst[24:20];
    assign dec.rd      = inst[11:7];
    assign dec.reg_wen = is_auipc | is_lui | is_jal | is_jalr | is_addi | is_add | is_lw;
    assign dec.mem_en  = is_lw;
    // only the exact ebreak word halts
    assign dec.ebreak  = hot_opcode[OPC_SYSTEM] & (inst == EBREAK_INSN);

endmodule

/* src/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import npc_pkg::*;

    alu_op_t  op;
    // immediate, already shaped for the instruction format
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     reg_wen;
    logic     mem_en;
    logic     ebreak;

    modport decoder (
        output op, imm, rs1, rs2, rd, reg_wen, mem_en, ebreak
    );

    modport alu (
        input op, imm
    );

    modport regs (
        input rs1, rs2, rd, reg_wen
    );

    modport pcu (
        input op, ebreak
    );

endinterface

/* src/npc_pkg.sv */
package npc_pkg;

    // operation selected by the decoder, one per supported instruction
    typedef enum logic [3:0] {
        ALU_NONE  = 4'd0,
        ALU_AUIPC = 4'd1,
        ALU_LUI   = 4'd2,
        ALU_JAL   = 4'd3,
        ALU_JALR  = 4'd4,
        ALU_ADDI  = 4'd5,
        ALU_ADD   = 4'd6,
        ALU_LW    = 4'd7
    } alu_op_t;

    // register index
    typedef logic [4:0] reg_idx_t;

    // data and address word
    typedef logic [31:0] word_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 values used by the subset
    localparam logic [2:0] F3_ZERO = 3'd0;
    localparam logic [2:0] F3_WORD = 3'd2;

    // ebreak, treated as halt
    localparam word_t EBREAK_INSN = 32'h0010_0073;

endpackage
